//--- Makefile
SRCS := $(wildcard source/*.sv testbench/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_demo_system

obj_dir/Vtb_demo_system: list.f $(SRCS)
	verilator --binary --assert --top-module tb_demo_system -f list.f

run: obj_dir/Vtb_demo_system
	@out="$$(./obj_dir/Vtb_demo_system)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

//--- list.f
source/demo_pkg.sv
source/demo_bus.sv
source/demo_ram.sv
source/demo_gpio.sv
source/demo_timer.sv
source/demo_system.sv
testbench/tb_demo_system.sv

//--- source/demo_bus.sv
`timescale 1ns/10ps

module demo_bus (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  input  demo_pkg::bus_req_t host_req_i,
  output demo_pkg::bus_rsp_t host_rsp_o,

  output demo_pkg::bus_req_t ram_req_o,
  output demo_pkg::bus_req_t gpio_req_o,
  output demo_pkg::bus_req_t timer_req_o,

  input  demo_pkg::dev_rsp_t ram_rsp_i,
  input  demo_pkg::dev_rsp_t gpio_rsp_i,
  input  demo_pkg::dev_rsp_t timer_rsp_i
);

  demo_pkg::bus_device_e dev_sel;
  demo_pkg::bus_device_e dev_sel_q;
  logic                  err_q;

  // copy of the host request for one device, base stripped
  function automatic demo_pkg::bus_req_t route_req(input demo_pkg::bus_req_t req,
                                                   input logic hit,
                                                   input logic [demo_pkg::BUS_AW-1:0] mask);
    demo_pkg::bus_req_t dev_req;
    dev_req      = req;
    dev_req.req  = req.req & hit;
    dev_req.addr = req.addr & ~mask;
    return dev_req;
  endfunction

  // decode stage
  // match address against the fixed map
  always_comb begin
    if ((host_req_i.addr & demo_pkg::RAM_MASK) == demo_pkg::RAM_START) begin
      dev_sel = demo_pkg::DEV_RAM;
    end else if ((host_req_i.addr & demo_pkg::GPIO_MASK) == demo_pkg::GPIO_START) begin
      dev_sel = demo_pkg::DEV_GPIO;
    end else if ((host_req_i.addr & demo_pkg::TIMER_MASK) == demo_pkg::TIMER_START) begin
      dev_sel = demo_pkg::DEV_TIMER;
    end else begin
      // unmapped, no device sees the request
      dev_sel = demo_pkg::DEV_NONE;
    end
  end

  // req only reaches the selected device
  assign ram_req_o   = route_req(host_req_i, dev_sel == demo_pkg::DEV_RAM, demo_pkg::RAM_MASK);
  assign gpio_req_o  = route_req(host_req_i, dev_sel == demo_pkg::DEV_GPIO, demo_pkg::GPIO_MASK);
  assign timer_req_o = route_req(host_req_i, dev_sel == demo_pkg::DEV_TIMER,
                                 demo_pkg::TIMER_MASK);

  // remember target for the response stage
  // idle cycles park on DEV_NONE with no error pending
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      dev_sel_q <= demo_pkg::DEV_NONE;
      err_q     <= 1'b0;
    end else begin
      dev_sel_q <= host_req_i.req ? dev_sel : demo_pkg::DEV_NONE;
      err_q     <= host_req_i.req && (dev_sel == demo_pkg::DEV_NONE);
    end
  end

  // response stage
  always_comb begin
    // every request granted at once
    host_rsp_o.gnt = host_req_i.req;
    case (dev_sel_q)
      demo_pkg::DEV_RAM: begin
        host_rsp_o.rvalid = ram_rsp_i.rvalid;
        host_rsp_o.err    = 1'b0;
        host_rsp_o.rdata  = ram_rsp_i.rdata;
      end
      demo_pkg::DEV_GPIO: begin
        host_rsp_o.rvalid = gpio_rsp_i.rvalid;
        host_rsp_o.err    = 1'b0;
        host_rsp_o.rdata  = gpio_rsp_i.rdata;
      end
      demo_pkg::DEV_TIMER: begin
        host_rsp_o.rvalid = timer_rsp_i.rvalid;
        host_rsp_o.err    = 1'b0;
        host_rsp_o.rdata  = timer_rsp_i.rdata;
      end
      default: begin
        // error reply for an unmapped access, zero data
        host_rsp_o.rvalid = err_q;
        host_rsp_o.err    = err_q;
        host_rsp_o.rdata  = '0;
      end
    endcase
  end

  // one device at most per cycle
  a_dev_req_onehot: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $onehot0({ram_req_o.req, gpio_req_o.req, timer_req_o.req}));

  // device replies must line up with the one-cycle response
  a_rsp_next_cycle: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_req_i.req |=> host_rsp_o.rvalid);

endmodule

//--- source/demo_gpio.sv
`timescale 1ns/10ps

module demo_gpio (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  input  demo_pkg::bus_req_t             req_i,
  output demo_pkg::dev_rsp_t             rsp_o,

  input  logic [demo_pkg::GPI_WIDTH-1:0] gp_i,
  output logic [demo_pkg::GPO_WIDTH-1:0] gp_o
);

  logic [demo_pkg::BUS_AW-1:0]    reg_off;
  logic [demo_pkg::BUS_DW-1:0]    wmask;
  logic [demo_pkg::GPO_WIDTH-1:0] gpo_q;
  logic [demo_pkg::GPI_WIDTH-1:0] gpi_meta_q;
  logic [demo_pkg::GPI_WIDTH-1:0] gpi_sync_q;
  logic [demo_pkg::BUS_DW-1:0]    rdata_d;
  logic [demo_pkg::BUS_DW-1:0]    rdata_q;
  logic                           rvalid_q;

  // word aligned register offset
  assign reg_off = {req_i.addr[demo_pkg::BUS_AW-1:2], 2'b00};
  assign wmask   = demo_pkg::be_to_mask(req_i.be);

  // output register, byte enables apply
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q <= '0;
    end else if (req_i.req && req_i.we && (reg_off == demo_pkg::GPIO_OUT_OFF)) begin
      gpo_q <= (gpo_q & ~wmask[demo_pkg::GPO_WIDTH-1:0]) |
               (req_i.wdata[demo_pkg::GPO_WIDTH-1:0] & wmask[demo_pkg::GPO_WIDTH-1:0]);
    end
  end

  // two flop synchronizer on the async inputs
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  // read mux, zero extended
  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      if (reg_off == demo_pkg::GPIO_OUT_OFF) begin
        rdata_d[demo_pkg::GPO_WIDTH-1:0] = gpo_q;
      end else if (reg_off == demo_pkg::GPIO_IN_OFF) begin
        rdata_d[demo_pkg::GPI_WIDTH-1:0] = gpi_sync_q;
      end
    end
  end

  // payload only
  always_ff @(posedge clk_sys_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign gp_o         = gpo_q;

endmodule

//--- source/demo_pkg.sv
package demo_pkg;

  // bus widths
  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;
  localparam int BUS_BW = 4;

  // address map, each region matches on bits above its size
  localparam logic [BUS_AW-1:0] RAM_START   = 32'h0000_0000;
  localparam logic [BUS_AW-1:0] RAM_SIZE    = 32'h0000_1000;
  localparam logic [BUS_AW-1:0] RAM_MASK    = ~(RAM_SIZE - 1);
  localparam int                RAM_WORDS   = RAM_SIZE / (BUS_DW / 8);

  localparam logic [BUS_AW-1:0] GPIO_START  = 32'h8000_0000;
  localparam logic [BUS_AW-1:0] GPIO_SIZE   = 32'h0000_1000;
  localparam logic [BUS_AW-1:0] GPIO_MASK   = ~(GPIO_SIZE - 1);

  localparam logic [BUS_AW-1:0] TIMER_START = 32'h8000_2000;
  localparam logic [BUS_AW-1:0] TIMER_SIZE  = 32'h0000_1000;
  localparam logic [BUS_AW-1:0] TIMER_MASK  = ~(TIMER_SIZE - 1);

  // gpio port widths and register offsets
  localparam int                GPI_WIDTH    = 8;
  localparam int                GPO_WIDTH    = 16;
  localparam logic [BUS_AW-1:0] GPIO_OUT_OFF = 32'h0;
  localparam logic [BUS_AW-1:0] GPIO_IN_OFF  = 32'h4;

  // timer register offsets
  localparam logic [BUS_AW-1:0] TIMER_MTIME_LO_OFF    = 32'h0;
  localparam logic [BUS_AW-1:0] TIMER_MTIME_HI_OFF    = 32'h4;
  localparam logic [BUS_AW-1:0] TIMER_MTIMECMP_LO_OFF = 32'h8;
  localparam logic [BUS_AW-1:0] TIMER_MTIMECMP_HI_OFF = 32'hC;

  // decoded target of a request
  typedef enum logic [1:0] {
    DEV_RAM,
    DEV_GPIO,
    DEV_TIMER,
    DEV_NONE
  } bus_device_e;

  // host request, also reused per device
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BUS_BW-1:0] be;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
  } bus_req_t;

  // response back to host
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic              err;
    logic [BUS_DW-1:0] rdata;
  } bus_rsp_t;

  // reply from one device
  typedef struct packed {
    logic              rvalid;
    logic [BUS_DW-1:0] rdata;
  } dev_rsp_t;

  // expand byte enables into a bit mask
  function automatic logic [BUS_DW-1:0] be_to_mask(input logic [BUS_BW-1:0] be);
    logic [BUS_DW-1:0] mask;
    for (int i = 0; i < BUS_BW; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

//--- source/demo_ram.sv
`timescale 1ns/10ps

module demo_ram (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  input  demo_pkg::bus_req_t req_i,
  output demo_pkg::dev_rsp_t rsp_o
);

  localparam int IDX_W = $clog2(demo_pkg::RAM_WORDS);

  logic [demo_pkg::BUS_DW-1:0] mem [demo_pkg::RAM_WORDS];
  logic [IDX_W-1:0]            word_idx;
  logic [demo_pkg::BUS_DW-1:0] wmask;
  logic                        rvalid_q;
  logic [demo_pkg::BUS_DW-1:0] rdata_q;

  // word offset from the byte address
  assign word_idx = req_i.addr[2 +: IDX_W];
  assign wmask    = demo_pkg::be_to_mask(req_i.be);

  // storage and read data
  always_ff @(posedge clk_sys_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        // only enabled bytes change
        mem[word_idx] <= (mem[word_idx] & ~wmask) | (req_i.wdata & wmask);
        // writes answer with zero data
        rdata_q       <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  // one reply per request
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  // decoder must hand over an offset inside the ram
  a_idx_in_range: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    req_i.req |-> (req_i.addr[demo_pkg::BUS_AW-1:2] < demo_pkg::RAM_WORDS));

endmodule

//--- source/demo_system.sv
`timescale 1ns/10ps

module demo_system (
  input  logic                           clk_sys_i,
  input  logic                           rst_sys_ni,

  // single host port
  input  demo_pkg::bus_req_t             host_req_i,
  output demo_pkg::bus_rsp_t             host_rsp_o,

  // gpio pins
  input  logic [demo_pkg::GPI_WIDTH-1:0] gp_i,
  output logic [demo_pkg::GPO_WIDTH-1:0] gp_o,

  output logic                           timer_irq_o
);

  // per device request and reply
  demo_pkg::bus_req_t ram_req;
  demo_pkg::bus_req_t gpio_req;
  demo_pkg::bus_req_t timer_req;
  demo_pkg::dev_rsp_t ram_rsp;
  demo_pkg::dev_rsp_t gpio_rsp;
  demo_pkg::dev_rsp_t timer_rsp;

  demo_bus u_bus (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .host_req_i (host_req_i),
    .host_rsp_o (host_rsp_o),
    .ram_req_o  (ram_req),
    .gpio_req_o (gpio_req),
    .timer_req_o(timer_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_rsp_i (gpio_rsp),
    .timer_rsp_i(timer_rsp)
  );

  demo_ram u_ram (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (ram_req),
    .rsp_o     (ram_rsp)
  );

  demo_gpio u_gpio (
    .clk_sys_i (clk_sys_i),
    .rst_sys_ni(rst_sys_ni),
    .req_i     (gpio_req),
    .rsp_o     (gpio_rsp),
    .gp_i      (gp_i),
    .gp_o      (gp_o)
  );

  demo_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (timer_req),
    .rsp_o      (timer_rsp),
    .timer_irq_o(timer_irq_o)
  );

endmodule

//--- source/demo_timer.sv
`timescale 1ns/10ps

module demo_timer (
  input  logic               clk_sys_i,
  input  logic               rst_sys_ni,

  input  demo_pkg::bus_req_t req_i,
  output demo_pkg::dev_rsp_t rsp_o,

  output logic               timer_irq_o
);

  logic [demo_pkg::BUS_AW-1:0] reg_off;
  logic [demo_pkg::BUS_DW-1:0] wmask;
  logic                        wr;
  logic [63:0]                 mtime_q;
  logic [63:0]                 mtime_d;
  logic [63:0]                 mtimecmp_q;
  logic [63:0]                 mtimecmp_d;
  logic                        irq_q;
  logic [demo_pkg::BUS_DW-1:0] rdata_d;
  logic [demo_pkg::BUS_DW-1:0] rdata_q;
  logic                        rvalid_q;

  assign reg_off = {req_i.addr[demo_pkg::BUS_AW-1:2], 2'b00};
  assign wmask   = demo_pkg::be_to_mask(req_i.be);
  assign wr      = req_i.req && req_i.we;

  // next state of both counters
  // a write to mtime replaces the tick for that cycle
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (reg_off)
        demo_pkg::TIMER_MTIME_LO_OFF: begin
          mtime_d = {mtime_q[63:32], (mtime_q[31:0] & ~wmask) | (req_i.wdata & wmask)};
        end
        demo_pkg::TIMER_MTIME_HI_OFF: begin
          mtime_d = {(mtime_q[63:32] & ~wmask) | (req_i.wdata & wmask), mtime_q[31:0]};
        end
        demo_pkg::TIMER_MTIMECMP_LO_OFF: begin
          mtimecmp_d[31:0] = (mtimecmp_q[31:0] & ~wmask) | (req_i.wdata & wmask);
        end
        demo_pkg::TIMER_MTIMECMP_HI_OFF: begin
          mtimecmp_d[63:32] = (mtimecmp_q[63:32] & ~wmask) | (req_i.wdata & wmask);
        end
        default: begin
          // unknown offset, nothing written
        end
      endcase
    end
  end

  // read mux, value seen in the request cycle
  always_comb begin
    rdata_d = '0;
    if (!req_i.we) begin
      case (reg_off)
        demo_pkg::TIMER_MTIME_LO_OFF:    rdata_d = mtime_q[31:0];
        demo_pkg::TIMER_MTIME_HI_OFF:    rdata_d = mtime_q[63:32];
        demo_pkg::TIMER_MTIMECMP_LO_OFF: rdata_d = mtimecmp_q[31:0];
        demo_pkg::TIMER_MTIMECMP_HI_OFF: rdata_d = mtimecmp_q[63:32];
        default:                         rdata_d = '0;
      endcase
    end
  end

  // counters and registered compare
  // cmp of all ones keeps the irq quiet out of reset
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= req_i.req;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign timer_irq_o  = irq_q;

  // irq rise is judged against the compare value of the cycle before
  a_no_irq_cmp_max: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    $rose(timer_irq_o) |-> !(&$past(mtimecmp_q)));

endmodule

//--- testbench/tb_demo_system.sv
`timescale 1ns/10ps

module tb_demo_system;

  logic                     clk_sys_i = 1'b0;
  logic                     rst_sys_ni;
  demo_pkg::bus_req_t       host_req;
  demo_pkg::bus_rsp_t       host_rsp;
  logic [7:0]               gp_i;
  logic [15:0]              gp_o;
  logic                     timer_irq;

  // reference model state
  logic [31:0] ref_ram [1024];
  logic [15:0] ref_gpo = 16'h0;
  logic [7:0]  ref_gpi = 8'h0;

  // expectations in issue order
  logic [31:0] exp_data [$];
  logic        exp_err [$];
  logic        exp_chk [$];

  logic        rsp_due = 1'b0;
  logic [31:0] last_rdata;
  string       cur_test = "reset";
  int          errors = 0;
  int          errors_at_start;
  int          pass_count = 0;
  int          fail_count = 0;
  int          seed = 57;
  // all tests need under about 2000 cycles
  int          cycle_limit = 4000;
  int          cycles = 0;
  int          gap = 13;
  logic [9:0]  idx_list [256];
  logic [31:0] op;
  logic [31:0] wd;
  logic [31:0] t0;
  logic [31:0] t1;

  demo_system demo_system_i (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .host_req_i (host_req),
    .host_rsp_o (host_rsp),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .timer_irq_o(timer_irq)
  );

  // 4 ns period
  always #2 clk_sys_i = ~clk_sys_i;

  // expected rdata and err from the address map
  // timer reads depend on arrival time, so their data is not predicted
  function automatic void ref_access(input logic [31:0] addr, input logic we,
                                     input logic [3:0] be, input logic [31:0] wdata,
                                     output logic [31:0] rdata, output logic err,
                                     output logic chk);
    logic [31:0] mask;
    mask  = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    rdata = 32'h0;
    err   = 1'b0;
    chk   = 1'b1;
    if (addr < 32'h1000) begin
      if (we) begin
        ref_ram[addr[11:2]] = (ref_ram[addr[11:2]] & ~mask) | (wdata & mask);
      end else begin
        rdata = ref_ram[addr[11:2]];
      end
    end else if (addr[31:12] == 20'h80000) begin
      if (we && addr[11:2] == 10'd0) begin
        ref_gpo = (ref_gpo & ~mask[15:0]) | (wdata[15:0] & mask[15:0]);
      end else if (!we && addr[11:2] == 10'd0) begin
        rdata = {16'h0, ref_gpo};
      end else if (!we && addr[11:2] == 10'd1) begin
        rdata = {24'h0, ref_gpi};
      end
    end else if (addr[31:12] == 20'h80002) begin
      chk = we;
    end else begin
      // unmapped
      err = 1'b1;
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // one request per call, back to back when called in a row
  task automatic issue_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                           input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    logic        chk;
    @(posedge clk_sys_i);
    ref_access(addr, we, be, wdata, rdata, err, chk);
    host_req <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    exp_data.push_back(rdata);
    exp_err.push_back(err);
    exp_chk.push_back(chk);
  endtask

  task automatic drive_idle();
    @(posedge clk_sys_i);
    host_req <= '0;
  endtask

  // stop issuing and wait for every response
  task automatic drain_rsp();
    drive_idle();
    while (exp_err.size() != 0 || rsp_due) begin
      @(posedge clk_sys_i);
    end
  endtask

  task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    if (errors == errors_at_start) begin
      pass_count++;
      $display("PASS %s", cur_test);
    end else begin
      fail_count++;
      $display("FAIL %s", cur_test);
    end
  endtask

  // compare process, mid cycle where outputs are settled
  always @(negedge clk_sys_i) begin
    if (rst_sys_ni) begin
      check_value({cur_test, " gnt"}, {31'h0, host_req.req}, {31'h0, host_rsp.gnt});
      if (rsp_due) begin
        if (!host_rsp.rvalid) begin
          $display("%s: no rvalid in the cycle after a request", cur_test);
          errors++;
        end
        check_value({cur_test, " err"}, {31'h0, exp_err[0]}, {31'h0, host_rsp.err});
        if (exp_chk[0]) begin
          check_value({cur_test, " rdata"}, exp_data[0], host_rsp.rdata);
        end
        last_rdata = host_rsp.rdata;
        void'(exp_data.pop_front());
        void'(exp_err.pop_front());
        void'(exp_chk.pop_front());
      end else if (host_rsp.rvalid) begin
        $display("%s: rvalid seen with no request outstanding", cur_test);
        errors++;
      end
      // request presented now answers next cycle
      rsp_due = host_req.req;
    end
  end

  // watchdog
  always @(posedge clk_sys_i) begin
    cycles <= cycles + 1;
    if (cycles == cycle_limit) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    rst_sys_ni <= 1'b0;
    host_req   <= '0;
    gp_i       <= 8'h0;
    repeat (8) @(posedge clk_sys_i);
    rst_sys_ni <= 1'b1;
    @(posedge clk_sys_i);

    // full words first so partial writes never merge with unknown bytes
    start_test("ram_random");
    for (int i = 0; i < 256; i++) begin
      idx_list[i] = 10'($random(seed));
      issue_req({20'h0, idx_list[i], 2'b00}, 1'b1, 4'hf, $random(seed));
    end
    for (int i = 0; i < 256; i++) begin
      issue_req({20'h0, idx_list[i], 2'b00}, 1'b1, 4'($random(seed)), $random(seed));
    end
    for (int i = 0; i < 256; i++) begin
      issue_req({20'h0, idx_list[i], 2'b00}, 1'b0, 4'hf, 32'h0);
    end
    drain_rsp();
    finish_test();

    // one request every cycle, only initialized words are read
    start_test("back_to_back");
    for (int i = 0; i < 900; i++) begin
      op = $random(seed);
      if (op[1:0] == 2'd0) begin
        issue_req(32'h8000_0000, 1'b0, 4'hf, 32'h0);
      end else if (op[1:0] == 2'd1) begin
        issue_req({20'h0, idx_list[op[15:8]], 2'b00}, 1'b1, 4'hf, $random(seed));
      end else begin
        issue_req({20'h0, idx_list[op[15:8]], 2'b00}, 1'b0, 4'hf, 32'h0);
      end
    end
    drain_rsp();
    finish_test();

    start_test("gpio");
    issue_req(32'h8000_0000, 1'b1, 4'b0001, $random(seed));
    issue_req(32'h8000_0000, 1'b1, 4'b0010, $random(seed));
    drain_rsp();
    @(negedge clk_sys_i);
    check_value({cur_test, " gp_o"}, {16'h0, ref_gpo}, {16'h0, gp_o});
    issue_req(32'h8000_0000, 1'b0, 4'hf, 32'h0);
    drive_idle();
    wd = $random(seed);
    gp_i    <= wd[7:0];
    ref_gpi = wd[7:0];
    // two sync flops, read issued three cycles after the change
    repeat (2) @(posedge clk_sys_i);
    issue_req(32'h8000_0004, 1'b0, 4'hf, 32'h0);
    drain_rsp();
    finish_test();

    // ram word 0 would alias the unmapped offset if decode leaked
    start_test("unmapped");
    wd = $random(seed);
    issue_req(32'h0000_0000, 1'b1, 4'hf, wd);
    issue_req(32'h4000_0000, 1'b1, 4'hf, ~wd);
    issue_req(32'h4000_0000, 1'b0, 4'hf, 32'h0);
    issue_req(32'h0000_0000, 1'b0, 4'hf, 32'h0);
    drain_rsp();
    finish_test();

    start_test("timer");
    @(negedge clk_sys_i);
    check_value({cur_test, " irq idle"}, 32'h0, {31'h0, timer_irq});
    // high half first so the compare never dips below mtime early
    issue_req(32'h8000_200C, 1'b1, 4'hf, 32'h0);
    issue_req(32'h8000_2008, 1'b1, 4'hf, 32'h10);
    drain_rsp();
    repeat (2) @(negedge clk_sys_i);
    check_value({cur_test, " irq set"}, 32'h1, {31'h0, timer_irq});
    issue_req(32'h8000_2008, 1'b1, 4'hf, 32'hffff_ffff);
    issue_req(32'h8000_200C, 1'b1, 4'hf, 32'hffff_ffff);
    drain_rsp();
    repeat (2) @(negedge clk_sys_i);
    check_value({cur_test, " irq clear"}, 32'h0, {31'h0, timer_irq});
    // second read issued exactly gap edges after the first
    issue_req(32'h8000_2000, 1'b0, 4'hf, 32'h0);
    drive_idle();
    repeat (gap - 2) @(posedge clk_sys_i);
    t0 = last_rdata;
    issue_req(32'h8000_2000, 1'b0, 4'hf, 32'h0);
    drain_rsp();
    t1 = last_rdata;
    check_value({cur_test, " mtime delta"}, gap, t1 - t0);
    finish_test();

    $display("passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
